//--- rv_pkg.sv
// RV64 execute types
package rv_pkg;

  localparam int xlen = 64;

  // major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_imm32  = 7'b0011011;
  localparam logic [6:0] op_op     = 7'b0110011;
  localparam logic [6:0] op_op32   = 7'b0111011;
  localparam logic [6:0] op_system = 7'b1110011;

  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101; // srl or sra
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  localparam logic [2:0] f3_lb  = 3'b000;
  localparam logic [2:0] f3_lh  = 3'b001;
  localparam logic [2:0] f3_lw  = 3'b010;
  localparam logic [2:0] f3_ld  = 3'b011;
  localparam logic [2:0] f3_lbu = 3'b100;
  localparam logic [2:0] f3_lhu = 3'b101;
  localparam logic [2:0] f3_lwu = 3'b110;

  localparam logic [2:0] f3_csrrw  = 3'b001;
  localparam logic [2:0] f3_csrrs  = 3'b010;
  localparam logic [2:0] f3_csrrwi = 3'b101;
  localparam logic [2:0] f3_csrrsi = 3'b110;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000; // sub, sra
  localparam logic [5:0] f6_base = 6'b000000;  // rv64 immediate shifts
  localparam logic [5:0] f6_alt  = 6'b010000;

  localparam logic [31:0] inst_ebreak = 32'h0010_0073;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_e;

  // nine kinds, so four bits
  typedef enum logic [3:0] {
    br_seq, br_jal, br_jalr, br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu
  } br_e;

  typedef enum logic [1:0] {a_rs1, a_pc} a_sel_e;
  typedef enum logic [1:0] {b_rs2, b_imm, b_four} b_sel_e;
  typedef enum logic [1:0] {wb_alu, wb_load, wb_csr_old} wb_sel_e;
  typedef enum logic [1:0] {csr_none, csr_write, csr_set} csr_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv_r_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_i_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } rv_s_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } rv_b_t;

  // also carries the j-form immediate
  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_u_t;

  typedef union packed {
    rv_r_t r;
    rv_i_t i;
    rv_s_t s;
    rv_b_t b;
    rv_u_t u;
  } rv_inst_u;

  typedef struct packed {
    rv_inst_u        inst;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1;
    logic [xlen-1:0] rs2;
    logic [xlen-1:0] csr_rdata;
    logic [xlen-1:0] mem_rdata; // load data comes with the instruction
  } rv_issue_t;

  typedef struct packed {
    a_sel_e     a_sel;
    b_sel_e     b_sel;
    alu_op_e    alu_op;
    logic       word;
    br_e        br;
    wb_sel_e    wb_sel;
    logic [2:0] mem_op; // load funct3
    csr_op_e    csr_op;
    logic       use_zimm;
    logic       halt;
    logic       illegal;
  } rv_ctrl_t;

  typedef struct packed {
    rv_ctrl_t        ctrl;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] zimm;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1;
    logic [xlen-1:0] rs2;
    logic [xlen-1:0] csr_rdata;
    logic [xlen-1:0] mem_rdata;
  } rv_dec_t;

  typedef struct packed {
    rv_ctrl_t        ctrl;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] csr_wdata;
    logic [xlen-1:0] rs2;
    logic [xlen-1:0] csr_rdata;
    logic [xlen-1:0] mem_rdata;
  } rv_ex_t;

  typedef struct packed {
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] gpr_wdata;
    logic [xlen-1:0] csr_wdata;
    logic            halt;
    logic            illegal;
  } rv_retire_t;

endpackage

//--- rv_alu.sv
// 64-bit ALU
module rv_alu (
  input  logic [rv_pkg::xlen-1:0] i_src_a,
  input  logic [rv_pkg::xlen-1:0] i_src_b,
  input  rv_pkg::alu_op_e         i_alu_op,
  input  logic                    i_word,
  output logic [rv_pkg::xlen-1:0] o_result,
  output logic                    o_zero,
  output logic                    o_less,
  output logic                    o_less_u
);

  logic [5:0]              shamt;
  logic [rv_pkg::xlen-1:0] srl_src, sra_src, raw;

  // word shifts see only the low 32 bits of a
  assign shamt   = i_word ? {1'b0, i_src_b[4:0]} : i_src_b[5:0];
  assign srl_src = i_word ? {32'b0, i_src_a[31:0]} : i_src_a;
  assign sra_src = i_word ? {{32{i_src_a[31]}}, i_src_a[31:0]} : i_src_a;

  assign o_zero   = (i_src_a == i_src_b);
  assign o_less   = ($signed(i_src_a) < $signed(i_src_b));
  assign o_less_u = (i_src_a < i_src_b);

  always_comb begin
    case (i_alu_op)
      rv_pkg::alu_add:    raw = i_src_a + i_src_b;
      rv_pkg::alu_sub:    raw = i_src_a - i_src_b;
      rv_pkg::alu_sll:    raw = i_src_a << shamt;
      rv_pkg::alu_slt:    raw = {63'b0, o_less};
      rv_pkg::alu_sltu:   raw = {63'b0, o_less_u};
      rv_pkg::alu_xor:    raw = i_src_a ^ i_src_b;
      rv_pkg::alu_srl:    raw = srl_src >> shamt;
      rv_pkg::alu_sra:    raw = $signed(sra_src) >>> shamt;
      rv_pkg::alu_or:     raw = i_src_a | i_src_b;
      rv_pkg::alu_and:    raw = i_src_a & i_src_b;
      rv_pkg::alu_pass_b: raw = i_src_b;
      default:            raw = '0;
    endcase
  end

  // *w results sign-extend from bit 31
  assign o_result = i_word ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

//--- rv_decode.sv
// Instruction decode stage
module rv_decode (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_valid,
  input  rv_pkg::rv_issue_t i_issue,
  input  logic              i_ready,
  output logic              o_ready,
  output logic              o_valid,
  output rv_pkg::rv_dec_t   o_dec
);

  rv_pkg::rv_inst_u           inst;
  rv_pkg::rv_ctrl_t           ctrl;
  rv_pkg::rv_dec_t            dec_next;
  logic [2:0]                 f3;
  logic [6:0]                 f7;
  logic                       alt;
  logic [rv_pkg::xlen-1:0]    imm, imm_i, imm_b, imm_u, imm_j;

  function automatic rv_pkg::alu_op_e alu_of(input logic [2:0] fn3, input logic fn_alt,
                                             input logic reg_op);
    case (fn3)
      rv_pkg::f3_add:  return (fn_alt && reg_op) ? rv_pkg::alu_sub : rv_pkg::alu_add;
      rv_pkg::f3_sll:  return rv_pkg::alu_sll;
      rv_pkg::f3_slt:  return rv_pkg::alu_slt;
      rv_pkg::f3_sltu: return rv_pkg::alu_sltu;
      rv_pkg::f3_xor:  return rv_pkg::alu_xor;
      rv_pkg::f3_sr:   return fn_alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      rv_pkg::f3_or:   return rv_pkg::alu_or;
      default:         return rv_pkg::alu_and;
    endcase
  endfunction

  assign inst = i_issue.inst;
  assign f3   = inst.i.funct3;
  assign f7   = inst.r.funct7;
  assign alt  = f7[5];

  assign imm_i = {{52{inst.i.imm[11]}}, inst.i.imm};
  assign imm_b = {{51{inst.b.imm12}}, inst.b.imm12, inst.b.imm11, inst.b.imm10_5,
                  inst.b.imm4_1, 1'b0};
  assign imm_u = {{32{inst.u.imm[19]}}, inst.u.imm, 12'b0};
  assign imm_j = {{43{inst.u.imm[19]}}, inst.u.imm[19], inst.u.imm[7:0], inst.u.imm[8],
                  inst.u.imm[18:9], 1'b0}; // j bits reshuffled from the u view

  always_comb begin
    ctrl        = '0;
    ctrl.a_sel  = rv_pkg::a_rs1;
    ctrl.b_sel  = rv_pkg::b_imm;
    ctrl.alu_op = rv_pkg::alu_add;
    ctrl.br     = rv_pkg::br_seq;
    ctrl.wb_sel = rv_pkg::wb_alu;
    ctrl.csr_op = rv_pkg::csr_none;
    ctrl.mem_op = f3;
    imm         = imm_i;
    case (inst.r.opcode)
      rv_pkg::op_lui: begin
        ctrl.alu_op = rv_pkg::alu_pass_b;
        imm = imm_u;
      end
      rv_pkg::op_auipc: begin
        ctrl.a_sel = rv_pkg::a_pc;
        imm = imm_u;
      end
      rv_pkg::op_jal, rv_pkg::op_jalr: begin
        ctrl.a_sel = rv_pkg::a_pc; // link = pc + 4
        ctrl.b_sel = rv_pkg::b_four;
        if (inst.r.opcode == rv_pkg::op_jal) begin
          ctrl.br = rv_pkg::br_jal;
          imm = imm_j;
        end else begin
          ctrl.br = rv_pkg::br_jalr;
          ctrl.illegal = (f3 != 3'b000);
        end
      end
      rv_pkg::op_branch: begin
        ctrl.b_sel  = rv_pkg::b_rs2;
        ctrl.alu_op = rv_pkg::alu_sub;
        imm = imm_b;
        case (f3)
          rv_pkg::f3_beq:  ctrl.br = rv_pkg::br_beq;
          rv_pkg::f3_bne:  ctrl.br = rv_pkg::br_bne;
          rv_pkg::f3_blt:  ctrl.br = rv_pkg::br_blt;
          rv_pkg::f3_bge:  ctrl.br = rv_pkg::br_bge;
          rv_pkg::f3_bltu: ctrl.br = rv_pkg::br_bltu;
          rv_pkg::f3_bgeu: ctrl.br = rv_pkg::br_bgeu;
          default:         ctrl.illegal = 1'b1;
        endcase
      end
      rv_pkg::op_load: begin
        ctrl.wb_sel  = rv_pkg::wb_load;
        ctrl.illegal = (f3 == 3'b111);
      end
      rv_pkg::op_imm, rv_pkg::op_imm32: begin
        ctrl.word   = (inst.r.opcode == rv_pkg::op_imm32);
        ctrl.alu_op = alu_of(f3, alt, 1'b0);
        if (f3 == rv_pkg::f3_sll)
          ctrl.illegal = ctrl.word ? (f7 != rv_pkg::f7_base) : (f7[6:1] != rv_pkg::f6_base);
        else if (f3 == rv_pkg::f3_sr)
          ctrl.illegal = ctrl.word ? !(f7 == rv_pkg::f7_base || f7 == rv_pkg::f7_alt)
                                   : !(f7[6:1] == rv_pkg::f6_base || f7[6:1] == rv_pkg::f6_alt);
        else
          ctrl.illegal = ctrl.word && (f3 != rv_pkg::f3_add);
      end
      rv_pkg::op_op, rv_pkg::op_op32: begin
        ctrl.b_sel   = rv_pkg::b_rs2;
        ctrl.word    = (inst.r.opcode == rv_pkg::op_op32);
        ctrl.alu_op  = alu_of(f3, alt, 1'b1);
        ctrl.illegal = !(f7 == rv_pkg::f7_base ||
                         (f7 == rv_pkg::f7_alt && (f3 == rv_pkg::f3_add || f3 == rv_pkg::f3_sr)))
                       || (ctrl.word && !(f3 == rv_pkg::f3_add || f3 == rv_pkg::f3_sll ||
                                          f3 == rv_pkg::f3_sr));
      end
      rv_pkg::op_system: begin
        ctrl.wb_sel = rv_pkg::wb_csr_old;
        if (inst == rv_pkg::inst_ebreak) begin
          ctrl.halt   = 1'b1;
          ctrl.wb_sel = rv_pkg::wb_alu;
        end else begin
          case (f3)
            rv_pkg::f3_csrrw: ctrl.csr_op = rv_pkg::csr_write;
            rv_pkg::f3_csrrs: ctrl.csr_op = rv_pkg::csr_set;
            rv_pkg::f3_csrrwi: begin
              ctrl.csr_op   = rv_pkg::csr_write;
              ctrl.use_zimm = 1'b1;
            end
            rv_pkg::f3_csrrsi: begin
              ctrl.csr_op   = rv_pkg::csr_set;
              ctrl.use_zimm = 1'b1;
            end
            default: ctrl.illegal = 1'b1; // ecall, csrrc and friends
          endcase
        end
      end
      default: ctrl.illegal = 1'b1;
    endcase
  end

  always_comb begin
    dec_next.ctrl      = ctrl;
    dec_next.imm       = imm;
    dec_next.zimm      = {59'b0, inst.i.rs1};
    dec_next.pc        = i_issue.pc;
    dec_next.rs1       = i_issue.rs1;
    dec_next.rs2       = i_issue.rs2;
    dec_next.csr_rdata = i_issue.csr_rdata;
    dec_next.mem_rdata = i_issue.mem_rdata;
  end

  assign o_ready = !o_valid || i_ready;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n)
      o_valid <= 1'b0;
    else if (o_ready)
      o_valid <= i_valid;
  end

  always_ff @(posedge i_clk) begin
    if (o_ready && i_valid)
      o_dec <= dec_next;
  end

endmodule

//--- rv_exec.sv
// Execute stage
module rv_exec (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_valid,
  input  rv_pkg::rv_dec_t i_dec,
  input  logic            i_ready,
  output logic            o_ready,
  output logic            o_valid,
  output rv_pkg::rv_ex_t  o_ex
);

  logic [rv_pkg::xlen-1:0] src_a, src_b, alu_result;
  logic [rv_pkg::xlen-1:0] csr_src, csr_wdata, next_pc, jalr_target;
  logic                    zero, less, less_u, taken;
  rv_pkg::rv_ex_t          ex_next;

  assign src_a = (i_dec.ctrl.a_sel == rv_pkg::a_pc) ? i_dec.pc : i_dec.rs1;

  always_comb begin
    case (i_dec.ctrl.b_sel)
      rv_pkg::b_rs2:  src_b = i_dec.rs2;
      rv_pkg::b_four: src_b = 64'd4;
      default:        src_b = i_dec.imm;
    endcase
  end

  rv_alu u_alu (
    .i_src_a  (src_a),
    .i_src_b  (src_b),
    .i_alu_op (i_dec.ctrl.alu_op),
    .i_word   (i_dec.ctrl.word),
    .o_result (alu_result),
    .o_zero   (zero),
    .o_less   (less),
    .o_less_u (less_u)
  );

  always_comb begin
    case (i_dec.ctrl.br)
      rv_pkg::br_jal:  taken = 1'b1;
      rv_pkg::br_beq:  taken = zero;
      rv_pkg::br_bne:  taken = !zero;
      rv_pkg::br_blt:  taken = less;
      rv_pkg::br_bge:  taken = !less;
      rv_pkg::br_bltu: taken = less_u;
      rv_pkg::br_bgeu: taken = !less_u;
      default:         taken = 1'b0;
    endcase
  end

  assign jalr_target = (i_dec.rs1 + i_dec.imm) & ~64'd1;

  always_comb begin
    if (i_dec.ctrl.br == rv_pkg::br_jalr)
      next_pc = jalr_target;
    else if (taken)
      next_pc = i_dec.pc + i_dec.imm;
    else
      next_pc = i_dec.pc + 64'd4;
  end

  assign csr_src = i_dec.ctrl.use_zimm ? i_dec.zimm : i_dec.rs1;

  always_comb begin
    case (i_dec.ctrl.csr_op)
      rv_pkg::csr_write: csr_wdata = csr_src;
      rv_pkg::csr_set:   csr_wdata = i_dec.csr_rdata | csr_src;
      default:           csr_wdata = '0;
    endcase
  end

  always_comb begin
    ex_next.ctrl       = i_dec.ctrl;
    ex_next.alu_result = alu_result;
    ex_next.next_pc    = next_pc;
    ex_next.csr_wdata  = csr_wdata;
    ex_next.rs2        = i_dec.rs2;
    ex_next.csr_rdata  = i_dec.csr_rdata;
    ex_next.mem_rdata  = i_dec.mem_rdata;
  end

  assign o_ready = !o_valid || i_ready;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n)
      o_valid <= 1'b0;
    else if (o_ready)
      o_valid <= i_valid;
  end

  always_ff @(posedge i_clk) begin
    if (o_ready && i_valid)
      o_ex <= ex_next;
  end

endmodule

//--- rv_result.sv
// Result and write-back stage
module rv_result (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_valid,
  input  rv_pkg::rv_ex_t     i_ex,
  input  logic               i_ready,
  output logic               o_ready,
  output logic               o_valid,
  output rv_pkg::rv_retire_t o_retire
);

  logic [rv_pkg::xlen-1:0] rdata, load_data, gpr_wdata;
  rv_pkg::rv_retire_t      retire_next;

  assign rdata = i_ex.mem_rdata;

  always_comb begin
    case (i_ex.ctrl.mem_op)
      rv_pkg::f3_lb:  load_data = {{56{rdata[7]}}, rdata[7:0]};
      rv_pkg::f3_lh:  load_data = {{48{rdata[15]}}, rdata[15:0]};
      rv_pkg::f3_lw:  load_data = {{32{rdata[31]}}, rdata[31:0]};
      rv_pkg::f3_ld:  load_data = rdata;
      rv_pkg::f3_lbu: load_data = {56'b0, rdata[7:0]};
      rv_pkg::f3_lhu: load_data = {48'b0, rdata[15:0]};
      rv_pkg::f3_lwu: load_data = {32'b0, rdata[31:0]};
      default:        load_data = '0;
    endcase
  end

  always_comb begin
    case (i_ex.ctrl.wb_sel)
      rv_pkg::wb_load:    gpr_wdata = load_data;
      rv_pkg::wb_csr_old: gpr_wdata = i_ex.csr_rdata; // rd gets the old csr
      default:            gpr_wdata = i_ex.alu_result;
    endcase
  end

  always_comb begin
    retire_next.alu_result = i_ex.alu_result;
    retire_next.next_pc    = i_ex.next_pc;
    retire_next.gpr_wdata  = gpr_wdata;
    retire_next.csr_wdata  = i_ex.csr_wdata;
    retire_next.halt       = i_ex.ctrl.halt;
    retire_next.illegal    = i_ex.ctrl.illegal;
  end

  assign o_ready = !o_valid || i_ready;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n)
      o_valid <= 1'b0;
    else if (o_ready)
      o_valid <= i_valid;
  end

  always_ff @(posedge i_clk) begin
    if (o_ready && i_valid)
      o_retire <= retire_next;
  end

endmodule

//--- rv_exec_top.sv
// RV64 execute subsystem top
module rv_exec_top (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_issue_valid,
  input  rv_pkg::rv_issue_t  i_issue,
  output logic               o_issue_ready,
  output logic               o_retire_valid,
  input  logic               i_retire_ready,
  output rv_pkg::rv_retire_t o_retire
);

  logic            dec_valid, dec_ready;
  logic            ex_valid, ex_ready;
  rv_pkg::rv_dec_t dec;
  rv_pkg::rv_ex_t  ex;

  rv_decode u_decode (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_valid (i_issue_valid),
    .i_issue (i_issue),
    .i_ready (dec_ready),
    .o_ready (o_issue_ready),
    .o_valid (dec_valid),
    .o_dec   (dec)
  );

  rv_exec u_exec (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_valid (dec_valid),
    .i_dec   (dec),
    .i_ready (ex_ready),
    .o_ready (dec_ready),
    .o_valid (ex_valid),
    .o_ex    (ex)
  );

  rv_result u_result (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_valid  (ex_valid),
    .i_ex     (ex),
    .i_ready  (i_retire_ready),
    .o_ready  (ex_ready),
    .o_valid  (o_retire_valid),
    .o_retire (o_retire)
  );

endmodule

//--- tb_rv_exec.sv
// RV64 execute testbench
module tb_rv_exec;

  localparam int n_trans    = 400;
  localparam int max_cycles = n_trans * 10; // ten cycles per item is ample

  typedef struct packed {
    rv_pkg::rv_retire_t ret;
    logic               chk_alu; // alu_result defined for this class
    logic               chk_gpr;
  } expect_t;

  logic               clk, rst_n;
  logic               issue_valid, issue_ready;
  rv_pkg::rv_issue_t  issue;
  logic               retire_valid, retire_ready;
  rv_pkg::rv_retire_t retire;

  logic [31:0] lfsr;
  expect_t     q_exp[$];
  int          errors  = 0;
  int          checked = 0;
  int          issued  = 0;
  int          retired = 0;
  int          cycles  = 0;

  rv_exec_top uut (
    .i_clk          (clk),
    .i_rst_n        (rst_n),
    .i_issue_valid  (issue_valid),
    .i_issue        (issue),
    .o_issue_ready  (issue_ready),
    .o_retire_valid (retire_valid),
    .i_retire_ready (retire_ready),
    .o_retire       (retire)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[62:0], lfsr[0]};
    end
  endtask

  function automatic logic [63:0] sext32(input logic [31:0] w);
    return {{32{w[31]}}, w};
  endfunction

  function automatic logic [63:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic word, input logic [63:0] a,
                                          input logic [63:0] b);
    logic [63:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = word ? {32'b0, a[31:0] << b[4:0]} : a << b[5:0];
      3'd2: r = {63'b0, $signed(a) < $signed(b)};
      3'd3: r = {63'b0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (word && alt)
          r = {32'b0, $signed(a[31:0]) >>> b[4:0]};
        else if (word)
          r = {32'b0, a[31:0] >> b[4:0]};
        else if (alt)
          r = $signed(a) >>> b[5:0];
        else
          r = a >> b[5:0];
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return word ? sext32(r[31:0]) : r;
  endfunction

  // size from funct3[1:0], zero extend when funct3[2] is set
  function automatic logic [63:0] load_ref(input logic [2:0] f3, input logic [63:0] d);
    logic [63:0] mask;
    int          bits;
    bits = 8 << f3[1:0];
    if (bits == 64)
      return d;
    mask = (64'd1 << bits) - 64'd1;
    if (!f3[2] && d[bits-1])
      return d | ~mask;
    return d & mask;
  endfunction

  function automatic expect_t model(input rv_pkg::rv_issue_t p);
    expect_t     e;
    logic [31:0] ins;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [63:0] imm_i, imm_b, imm_u, imm_j, src, pc4;
    logic        taken;
    ins   = p.inst;
    opc   = ins[6:0];
    f3    = ins[14:12];
    imm_i = {{52{ins[31]}}, ins[31:20]};
    imm_b = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_u = sext32({ins[31:12], 12'b0});
    imm_j = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    pc4   = p.pc + 64'd4;
    e = '0;
    e.chk_alu = 1'b1;
    e.chk_gpr = 1'b1;
    e.ret.next_pc = pc4;
    case (opc)
      rv_pkg::op_op, rv_pkg::op_op32:
        e.ret.alu_result = alu_ref(f3, ins[30], opc == rv_pkg::op_op32, p.rs1, p.rs2);
      rv_pkg::op_imm, rv_pkg::op_imm32:
        e.ret.alu_result = alu_ref(f3, f3 == 3'd5 && ins[30], opc == rv_pkg::op_imm32,
                                   p.rs1, imm_i);
      rv_pkg::op_lui:   e.ret.alu_result = imm_u;
      rv_pkg::op_auipc: e.ret.alu_result = p.pc + imm_u;
      rv_pkg::op_jal: begin
        e.ret.alu_result = pc4; // link
        e.ret.next_pc    = p.pc + imm_j;
      end
      rv_pkg::op_jalr: begin
        e.ret.alu_result = pc4;
        e.ret.next_pc    = (p.rs1 + imm_i) & ~64'd1;
      end
      rv_pkg::op_branch: begin
        case (f3)
          3'd0:    taken = (p.rs1 == p.rs2);
          3'd1:    taken = (p.rs1 != p.rs2);
          3'd4:    taken = ($signed(p.rs1) < $signed(p.rs2));
          3'd5:    taken = ($signed(p.rs1) >= $signed(p.rs2));
          3'd6:    taken = (p.rs1 < p.rs2);
          default: taken = (p.rs1 >= p.rs2);
        endcase
        if (taken)
          e.ret.next_pc = p.pc + imm_b;
        e.chk_alu = 1'b0;
        e.chk_gpr = 1'b0;
      end
      rv_pkg::op_load: begin
        e.ret.alu_result = p.rs1 + imm_i; // address
        e.ret.gpr_wdata  = load_ref(f3, p.mem_rdata);
      end
      rv_pkg::op_system: begin
        e.chk_alu = 1'b0;
        if (ins == rv_pkg::inst_ebreak) begin
          e.ret.halt = 1'b1;
          e.chk_gpr  = 1'b0;
        end else begin
          src = f3[2] ? {59'b0, ins[19:15]} : p.rs1;
          e.ret.csr_wdata = f3[1] ? (p.csr_rdata | src) : src;
          e.ret.gpr_wdata = p.csr_rdata;
        end
      end
      default: begin
        e.ret.illegal = 1'b1;
        e.chk_alu = 1'b0;
        e.chk_gpr = 1'b0;
      end
    endcase
    if (opc != rv_pkg::op_load && opc != rv_pkg::op_system)
      e.ret.gpr_wdata = e.ret.alu_result;
    return e;
  endfunction

  task automatic make_issue(output rv_pkg::rv_issue_t p);
    logic [63:0] r;
    logic [31:0] ins;
    logic [6:0]  opc;
    logic [2:0]  f3, f3w;
    logic        alt;
    int          cls;
    take_bits(4, r);
    cls = r[3:0] % 12;
    take_bits(32, r);
    ins = r[31:0];
    take_bits(3, r);
    f3  = r[2:0];
    f3w = (f3[1:0] == 2'd0) ? 3'd0 : (f3[1:0] == 2'd1) ? 3'd1 : 3'd5; // word forms
    take_bits(1, r);
    alt = r[0];
    opc = rv_pkg::op_op;
    case (cls)
      0: ins[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && alt) ? 7'h20 : 7'h00;
      1: begin
        opc = rv_pkg::op_imm;
        if (f3 == 3'd1 || f3 == 3'd5)
          ins[31:26] = (f3 == 3'd5 && alt) ? 6'h10 : 6'h00;
      end
      2: begin
        opc = rv_pkg::op_op32;
        f3  = f3w;
        ins[31:25] = ((f3 == 3'd0 || f3 == 3'd5) && alt) ? 7'h20 : 7'h00;
      end
      3: begin
        opc = rv_pkg::op_imm32;
        f3  = f3w;
        if (f3 != 3'd0)
          ins[31:25] = (f3 == 3'd5 && alt) ? 7'h20 : 7'h00;
      end
      4: opc = rv_pkg::op_lui;
      5: opc = rv_pkg::op_auipc;
      6: opc = rv_pkg::op_jal;
      7: begin
        opc = rv_pkg::op_jalr;
        f3  = 3'd0;
      end
      8: begin
        opc = rv_pkg::op_branch;
        if (f3[2:1] == 2'b01)
          f3[2] = 1'b1;
      end
      9: begin
        opc = rv_pkg::op_load;
        if (f3 == 3'd7)
          f3 = 3'd3;
      end
      10: begin
        opc = rv_pkg::op_system;
        f3  = {f3[1], f3[0], ~f3[0]}; // csrrw, csrrs, csrrwi, csrrsi
      end
      default: opc = 7'b0001011; // custom-0, not decoded
    endcase
    ins[14:12] = f3;
    ins[6:0]   = opc;
    if (cls == 11 && alt)
      ins = rv_pkg::inst_ebreak;
    p.inst = ins;
    take_bits(64, r);
    p.pc = {r[63:2], 2'b00};
    take_bits(64, r);
    p.rs1 = r;
    take_bits(64, r);
    p.rs2 = r;
    take_bits(2, r);
    if (r[1:0] == 2'b00)
      p.rs2 = p.rs1; // equal operands for beq and bge
    take_bits(64, r);
    p.csr_rdata = r;
    take_bits(64, r);
    p.mem_rdata = r;
  endtask

  task automatic compare_field(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
    checked++;
    assert (act === exp) else begin
      errors++;
      $display("Fail t=%0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic print_summary();
    $display("errors %0d, checks %0d, issued %0d, retired %0d",
             errors, checked, issued, retired);
  endtask

  // scoreboard
  initial begin
    expect_t e;
    forever begin
      @(negedge clk);
      #1;
      if (retire_valid && retire_ready) begin
        retired++;
        assert (q_exp.size() != 0) else begin
          errors++;
          $display("packet retired at t=%0t while no issued packet was waiting", $time);
        end
        if (q_exp.size() != 0) begin
          e = q_exp.pop_front();
          if (e.chk_alu)
            compare_field("alu_result", e.ret.alu_result, retire.alu_result);
          if (e.chk_gpr)
            compare_field("gpr_wdata", e.ret.gpr_wdata, retire.gpr_wdata);
          compare_field("next_pc", e.ret.next_pc, retire.next_pc);
          compare_field("csr_wdata", e.ret.csr_wdata, retire.csr_wdata);
          compare_field("halt", 64'(e.ret.halt), 64'(retire.halt));
          compare_field("illegal", 64'(e.ret.illegal), 64'(retire.illegal));
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout, the run did not finish within %0d cycles", max_cycles);
      print_summary();
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    rv_pkg::rv_issue_t pkt;
    logic [63:0]       r;
    logic              fired;
    lfsr         = 32'd63270;
    fired        = 1'b0;
    rst_n        = 1'b0;
    issue_valid  = 1'b0;
    issue        = '0;
    retire_ready = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    while (issued < n_trans) begin
      @(negedge clk);
      if (fired)
        issue_valid = 1'b0;
      take_bits(2, r);
      retire_ready = (r[1:0] != 2'b00);
      if (!issue_valid) begin
        take_bits(2, r);
        if (r[1:0] != 2'b00) begin // gap one time in four
          make_issue(pkt);
          issue       = pkt;
          issue_valid = 1'b1;
        end
      end
      #1;
      fired = issue_valid && issue_ready;
      if (fired) begin
        q_exp.push_back(model(issue));
        issued++;
      end
    end
    @(negedge clk);
    issue_valid  = 1'b0;
    retire_ready = 1'b1;
    while (retired < issued)
      @(negedge clk);
    repeat (4) @(negedge clk);
    assert (q_exp.size() == 0) else begin
      errors++;
      $display("%0d expected packets never retired", q_exp.size());
    end
    print_summary();
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- compile.f
rv_pkg.sv
rv_alu.sv
rv_decode.sv
rv_exec.sv
rv_result.sv
rv_exec_top.sv
tb_rv_exec.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the rv64 execute testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_rv_exec -f compile.f -o tb_rv_exec_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_rv_exec_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$log"; then
  exit 1
fi
if ! grep -q "TESTS PASSED" "$log"; then
  echo "no result line found in $log"
  exit 1
fi
exit 0
